//--- hw/ft_loop_pkg.sv
`default_nettype none

package ft_loop_pkg;

	//====================================================================
	// Data widths
	//====================================================================

	// One byte on the FIFO chip data bus
	typedef logic [7:0] byte_t;

	// Length, service and payload words
	typedef logic [15:0] word_t;

	// Payload RAM word address
	typedef logic [10:0] ram_addr_t;

	//====================================================================
	// Frame constants
	//====================================================================

	// Start of frame, twelve of these in a row
	localparam byte_t HEADER_SYMBOL = 8'h55;
	localparam int    HEADER_COUNT  = 12;

	// End of frame
	localparam byte_t TRAILER_SYMBOL = 8'hAA;
	localparam int    TRAILER_COUNT  = 8;

	// Service code of an error reply
	localparam word_t ERROR_SERVICE = 16'hEEEE;

	// Length field covers length, service, payload and trailer
	localparam word_t MIN_LENGTH = 16'd12;

	// Payload buffer depth in words
	localparam int RAM_WORDS = 2048;

	// Receive side FSM
	typedef enum logic [2:0] {
		HUNT,
		LEN_LO,
		LEN_HI,
		SRV_LO,
		SRV_HI,
		PAYLOAD,
		TRAILER,
		HOLD
	} parser_state_t;

endpackage

`default_nettype wire

//--- hw/ft_rx_port.sv
`default_nettype none

module ft_rx_port import ft_loop_pkg::*; #(
	parameter int RD_CYCLE        = 25,
	parameter int RD_STROBE_START = 2,
	parameter int RD_STROBE_STOP  = 12,
	parameter int RD_SAMPLE       = 9
) (
	input  wire logic  clk,
	input  wire logic  arst_n,
	input  wire logic  rxf_n,
	output logic       rd_n,
	input  wire byte_t ft_data_in,
	output byte_t      rx_byte,
	output logic       rx_valid,
	input  wire logic  rx_ready,
	output logic       rd_busy
);

	localparam int CNT_W = $clog2(RD_CYCLE + 1);

	logic [1:0]       rxf_sync;
	logic             busy;
	logic             start;
	logic [CNT_W-1:0] cnt;
	logic             rd_strobe;

	// Two flops on rxf_n, idle value is "no data"
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rxf_sync <= 2'b11;
		end else begin
			rxf_sync <= {rxf_sync[0], rxf_n};
		end
	end

	// New read only when the chip has data and the parser can take it
	assign start = !busy && !rxf_sync[1] && rx_ready;

	//====================================================================
	// Read cycle timer
	//====================================================================

	// Counts 0 to RD_CYCLE, so RD_CYCLE+1 clocks per byte
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt  <= '0;
		end else if (busy) begin
			if (cnt == CNT_W'(RD_CYCLE)) begin
				busy <= 1'b0;
				cnt  <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Read strobe window
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_strobe <= 1'b0;
		end else if (busy && cnt == CNT_W'(RD_STROBE_START)) begin
			rd_strobe <= 1'b1;
		end else if (busy && cnt == CNT_W'(RD_STROBE_STOP)) begin
			rd_strobe <= 1'b0;
		end
	end

	// Byte valid on the cycle after the sample point
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= busy && cnt == CNT_W'(RD_SAMPLE);
		end
	end

	// Sample the bus while rd_n is still low
	always_ff @(posedge clk) begin
		if (busy && cnt == CNT_W'(RD_SAMPLE)) begin
			rx_byte <= ft_data_in;
		end
	end

	assign rd_n    = !rd_strobe;
	assign rd_busy = busy;

endmodule

`default_nettype wire

//--- hw/packet_parser.sv
`default_nettype none

module packet_parser import ft_loop_pkg::*; (
	input  wire logic  clk,
	input  wire logic  arst_n,
	input  wire byte_t rx_byte,
	input  wire logic  rx_valid,
	output logic       rx_ready,
	output logic       wr_en,
	output ram_addr_t  wr_addr,
	output word_t      wr_data,
	output logic       reply_valid,
	input  wire logic  reply_ready,
	output word_t      reply_length,
	output word_t      reply_service,
	output logic       reply_error,
	output logic       packet_active
);

	localparam int HDR_W = $clog2(HEADER_COUNT);
	localparam int TRL_W = $clog2(TRAILER_COUNT);

	parser_state_t    state;
	logic [HDR_W-1:0] hdr_cnt;
	logic [TRL_W-1:0] trl_cnt;
	word_t            pay_left;
	ram_addr_t        word_addr;
	logic             error_q;
	word_t            length_q;
	word_t            service_q;
	byte_t            low_byte;
	word_t            length_in;
	logic             trl_bad;

	// Full length as seen on the high byte
	assign length_in = {rx_byte, length_q[7:0]};
	assign trl_bad   = rx_byte != TRAILER_SYMBOL;

	//====================================================================
	// Frame FSM
	//====================================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= HUNT;
			hdr_cnt   <= '0;
			trl_cnt   <= '0;
			pay_left  <= '0;
			word_addr <= '0;
			error_q   <= 1'b0;
		end else begin
			case (state)
				HUNT: if (rx_valid) begin
					// Consecutive 0x55 run, anything else starts over
					if (rx_byte != HEADER_SYMBOL) begin
						hdr_cnt <= '0;
					end else if (hdr_cnt == HDR_W'(HEADER_COUNT - 1)) begin
						hdr_cnt   <= '0;
						trl_cnt   <= '0;
						word_addr <= '0;
						error_q   <= 1'b0;
						state     <= LEN_LO;
					end else begin
						hdr_cnt <= hdr_cnt + 1'b1;
					end
				end
				LEN_LO: if (rx_valid) state <= LEN_HI;
				LEN_HI: if (rx_valid) begin
					pay_left <= length_in - MIN_LENGTH;
					// Short or odd length ends the frame at once
					if (length_in < MIN_LENGTH || length_in[0]) begin
						error_q <= 1'b1;
						state   <= HOLD;
					end else begin
						state <= SRV_LO;
					end
				end
				SRV_LO: if (rx_valid) state <= SRV_HI;
				SRV_HI: if (rx_valid) begin
					state <= (pay_left == '0) ? TRAILER : PAYLOAD;
				end
				PAYLOAD: if (rx_valid) begin
					pay_left <= pay_left - 1'b1;
					// Odd count left means a high byte and a finished word
					if (pay_left[0]) begin
						word_addr <= word_addr + 1'b1;
					end
					if (pay_left == 16'd1) begin
						state <= TRAILER;
					end
				end
				TRAILER: if (rx_valid) begin
					if (trl_bad) begin
						error_q <= 1'b1;
					end
					trl_cnt <= trl_cnt + 1'b1;
					if (trl_cnt == TRL_W'(TRAILER_COUNT - 1)) begin
						state <= HOLD;
					end
				end
				// Wait for the sender to latch the result
				HOLD: if (reply_ready) state <= HUNT;
				default: state <= HUNT;
			endcase
		end
	end

	// Field and payload byte capture
	always_ff @(posedge clk) begin
		if (rx_valid && state == LEN_LO) length_q[7:0] <= rx_byte;
		if (rx_valid && state == LEN_HI) length_q[15:8] <= rx_byte;
		if (rx_valid && state == SRV_LO) service_q[7:0] <= rx_byte;
		if (rx_valid && state == SRV_HI) service_q[15:8] <= rx_byte;
		if (rx_valid && state == PAYLOAD && !pay_left[0]) low_byte <= rx_byte;
	end

	// RAM write on the high byte, lands on the next edge
	assign wr_en   = rx_valid && state == PAYLOAD && pay_left[0];
	assign wr_addr = word_addr;
	assign wr_data = {rx_byte, low_byte};

	assign rx_ready      = state != HOLD;
	assign reply_valid   = state == HOLD;
	assign reply_length  = length_q;
	assign reply_service = service_q;
	assign reply_error   = error_q;
	assign packet_active = state inside {LEN_LO, LEN_HI, SRV_LO, SRV_HI, PAYLOAD, TRAILER};

endmodule

`default_nettype wire

//--- hw/payload_ram.sv
`default_nettype none

module payload_ram import ft_loop_pkg::*; (
	input  wire logic      clk,
	input  wire logic      wr_en,
	input  wire ram_addr_t wr_addr,
	input  wire word_t     wr_data,
	input  wire ram_addr_t rd_addr,
	output word_t          rd_data
);

	// Payload words of one packet
	word_t mem [RAM_WORDS];

	// Write port from the parser
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read for the sender
	// one clock from address to data
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hw/reply_sender.sv
`default_nettype none

module reply_sender import ft_loop_pkg::*; (
	input  wire logic  clk,
	input  wire logic  arst_n,
	input  wire logic  reply_valid,
	output logic       reply_ready,
	input  wire word_t reply_length,
	input  wire word_t reply_service,
	input  wire logic  reply_error,
	output ram_addr_t  rd_addr,
	input  wire word_t rd_data,
	output byte_t      tx_byte,
	output logic       tx_valid,
	input  wire logic  tx_ready
);

	// Header plus a 16 bit length needs 17 bits of index
	localparam int IDX_W     = 17;
	localparam int PAY_START = HEADER_COUNT + 4;

	logic             active;
	logic             take;
	logic             load;
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] pay_end;
	logic [IDX_W-1:0] last_idx;
	logic             in_payload;
	word_t            len_q;
	word_t            srv_q;
	byte_t            hi_hold;
	byte_t            next_byte;

	assign reply_ready = !active;
	assign take        = reply_valid && !active;
	// One cycle between bytes to build the next one
	assign load        = active && !tx_valid;

	// Payload ends where the trailer starts
	assign pay_end    = IDX_W'(len_q) + IDX_W'(HEADER_COUNT - TRAILER_COUNT);
	assign last_idx   = IDX_W'(len_q) + IDX_W'(HEADER_COUNT - 1);
	assign in_payload = idx >= IDX_W'(PAY_START) && idx < pay_end;

	//====================================================================
	// Byte select
	//====================================================================
	always_comb begin
		if (idx < IDX_W'(HEADER_COUNT)) begin
			next_byte = HEADER_SYMBOL;
		end else if (idx == IDX_W'(HEADER_COUNT)) begin
			next_byte = len_q[7:0];
		end else if (idx == IDX_W'(HEADER_COUNT + 1)) begin
			next_byte = len_q[15:8];
		end else if (idx == IDX_W'(HEADER_COUNT + 2)) begin
			next_byte = srv_q[7:0];
		end else if (idx == IDX_W'(HEADER_COUNT + 3)) begin
			next_byte = srv_q[15:8];
		end else if (in_payload) begin
			// Even index is the low byte, straight from RAM
			next_byte = idx[0] ? hi_hold : rd_data[7:0];
		end else begin
			next_byte = TRAILER_SYMBOL;
		end
	end

	//====================================================================
	// Sequencer
	//====================================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active   <= 1'b0;
			tx_valid <= 1'b0;
			idx      <= '0;
			rd_addr  <= '0;
		end else if (take) begin
			active  <= 1'b1;
			idx     <= '0;
			rd_addr <= '0;
		end else if (load) begin
			tx_valid <= 1'b1;
			// Low byte taken, start fetching the next word
			if (in_payload && !idx[0]) begin
				rd_addr <= rd_addr + 1'b1;
			end
		end else if (tx_valid && tx_ready) begin
			tx_valid <= 1'b0;
			if (idx == last_idx) begin
				active <= 1'b0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// Reply fields and outgoing byte
	always_ff @(posedge clk) begin
		if (take) begin
			len_q <= reply_error ? MIN_LENGTH : reply_length;
			srv_q <= reply_error ? ERROR_SERVICE : reply_service;
		end
		if (load) begin
			tx_byte <= next_byte;
			// Keep the high half while rd_addr moves on
			if (in_payload && !idx[0]) begin
				hi_hold <= rd_data[15:8];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/ft_tx_port.sv
`default_nettype none

module ft_tx_port import ft_loop_pkg::*; #(
	parameter int WR_CYCLE        = 25,
	parameter int WR_STROBE_START = 5,
	parameter int WR_STROBE_STOP  = 15,
	parameter int WR_DRIVE_START  = 2,
	parameter int WR_DRIVE_STOP   = 22
) (
	input  wire logic  clk,
	input  wire logic  arst_n,
	input  wire logic  txe_n,
	output logic       wr,
	output byte_t      ft_data_out,
	output logic       ft_oe,
	input  wire byte_t tx_byte,
	input  wire logic  tx_valid,
	output logic       tx_ready,
	output logic       wr_busy
);

	localparam int CNT_W = $clog2(WR_CYCLE + 1);

	logic [1:0]       txe_sync;
	logic             busy;
	logic [CNT_W-1:0] cnt;

	// Two flops on txe_n, idle value is "chip full"
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			txe_sync <= 2'b11;
		end else begin
			txe_sync <= {txe_sync[0], txe_n};
		end
	end

	// Accept only when idle and the chip has room
	assign tx_ready = !busy && !txe_sync[1];

	//====================================================================
	// Write cycle timer and strobes
	//====================================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy  <= 1'b0;
			cnt   <= '0;
			wr    <= 1'b0;
			ft_oe <= 1'b0;
		end else begin
			if (tx_valid && tx_ready) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy && cnt == CNT_W'(WR_CYCLE)) begin
				busy <= 1'b0;
				cnt  <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
			end
			// Chip latches on the falling edge of wr
			if (busy && cnt == CNT_W'(WR_STROBE_START)) wr <= 1'b1;
			else if (busy && cnt == CNT_W'(WR_STROBE_STOP)) wr <= 1'b0;
			// Bus drive wraps the whole wr pulse
			if (busy && cnt == CNT_W'(WR_DRIVE_START)) ft_oe <= 1'b1;
			else if (busy && cnt == CNT_W'(WR_DRIVE_STOP)) ft_oe <= 1'b0;
		end
	end

	// Byte held for the whole cycle
	always_ff @(posedge clk) begin
		if (tx_valid && tx_ready) begin
			ft_data_out <= tx_byte;
		end
	end

	assign wr_busy = busy;

endmodule

`default_nettype wire

//--- hw/ft_packet_loopback.sv
`default_nettype none

module ft_packet_loopback import ft_loop_pkg::*; #(
	// FT245R read timing in clocks
	parameter int RD_CYCLE        = 25,
	parameter int RD_STROBE_START = 2,
	parameter int RD_STROBE_STOP  = 12,
	parameter int RD_SAMPLE       = 9,
	// FT245R write timing in clocks
	parameter int WR_CYCLE        = 25,
	parameter int WR_STROBE_START = 5,
	parameter int WR_STROBE_STOP  = 15,
	parameter int WR_DRIVE_START  = 2,
	parameter int WR_DRIVE_STOP   = 22
) (
	input  wire logic  clk,
	input  wire logic  arst_n,
	input  wire logic  rxf_n,
	output logic       rd_n,
	input  wire byte_t ft_data_in,
	input  wire logic  txe_n,
	output logic       wr,
	output byte_t      ft_data_out,
	output logic       ft_oe,
	output logic       usb_active,
	output logic       packet_active
);

	byte_t     rx_byte;
	logic      rx_valid;
	logic      rx_ready;
	logic      rd_busy;
	logic      wr_en;
	ram_addr_t wr_addr;
	word_t     wr_data;
	logic      reply_valid;
	logic      reply_ready;
	word_t     reply_length;
	word_t     reply_service;
	logic      reply_error;
	ram_addr_t rd_addr;
	word_t     rd_data;
	byte_t     tx_byte;
	logic      tx_valid;
	logic      tx_ready;
	logic      wr_busy;

	// Input side
	ft_rx_port #(
		.RD_CYCLE        (RD_CYCLE),
		.RD_STROBE_START (RD_STROBE_START),
		.RD_STROBE_STOP  (RD_STROBE_STOP),
		.RD_SAMPLE       (RD_SAMPLE)
	) u_rx (
		.clk        (clk),
		.arst_n     (arst_n),
		.rxf_n      (rxf_n),
		.rd_n       (rd_n),
		.ft_data_in (ft_data_in),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.rx_ready   (rx_ready),
		.rd_busy    (rd_busy)
	);

	// Frame decode and payload store
	packet_parser u_parser (
		.clk           (clk),
		.arst_n        (arst_n),
		.rx_byte       (rx_byte),
		.rx_valid      (rx_valid),
		.rx_ready      (rx_ready),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.reply_valid   (reply_valid),
		.reply_ready   (reply_ready),
		.reply_length  (reply_length),
		.reply_service (reply_service),
		.reply_error   (reply_error),
		.packet_active (packet_active)
	);

	payload_ram u_ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// Reply build
	reply_sender u_sender (
		.clk           (clk),
		.arst_n        (arst_n),
		.reply_valid   (reply_valid),
		.reply_ready   (reply_ready),
		.reply_length  (reply_length),
		.reply_service (reply_service),
		.reply_error   (reply_error),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.tx_byte       (tx_byte),
		.tx_valid      (tx_valid),
		.tx_ready      (tx_ready)
	);

	// Output side
	ft_tx_port #(
		.WR_CYCLE        (WR_CYCLE),
		.WR_STROBE_START (WR_STROBE_START),
		.WR_STROBE_STOP  (WR_STROBE_STOP),
		.WR_DRIVE_START  (WR_DRIVE_START),
		.WR_DRIVE_STOP   (WR_DRIVE_STOP)
	) u_tx (
		.clk         (clk),
		.arst_n      (arst_n),
		.txe_n       (txe_n),
		.wr          (wr),
		.ft_data_out (ft_data_out),
		.ft_oe       (ft_oe),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.tx_ready    (tx_ready),
		.wr_busy     (wr_busy)
	);

	// Any bus cycle in flight
	assign usb_active = rd_busy | wr_busy;

endmodule

`default_nettype wire

//--- tb/ft_packet_loopback_tb.sv
`default_nettype none

module ft_packet_loopback_tb import ft_loop_pkg::*; ();

	//====================================================================
	// Short bus timing for simulation
	//====================================================================
	localparam int RD_CYCLE        = 8;
	localparam int RD_STROBE_START = 1;
	localparam int RD_STROBE_STOP  = 4;
	localparam int RD_SAMPLE       = 3;
	localparam int WR_CYCLE        = 8;
	localparam int WR_STROBE_START = 2;
	localparam int WR_STROBE_STOP  = 5;
	localparam int WR_DRIVE_START  = 1;
	localparam int WR_DRIVE_STOP   = 7;

	// Request plus reply bytes of every test
	localparam int TOTAL_BYTES = (38 + 32) + (24 + 24) + (14 + 24) + (28 + 24) + (40 + 40);
	localparam int CYCLE_LIMIT = 4 * TOTAL_BYTES * (RD_CYCLE + WR_CYCLE + 8);

	logic  clk        = 1'b0;
	logic  arst_n     = 1'b0;
	logic  rxf_n      = 1'b1;
	byte_t ft_data_in = 8'h00;
	logic  txe_n      = 1'b0;
	logic  rd_n;
	logic  wr;
	byte_t ft_data_out;
	logic  ft_oe;
	logic  usb_active;
	logic  packet_active;

	// Chip side byte queues
	byte_t req_q[$];
	byte_t reply_q[$];
	// Per test request and expected reply
	byte_t stim_q[$];
	byte_t exp_q[$];
	// txe_n stretch lengths for back-pressure
	int    bp_q[$];

	logic [15:0] lfsr_q   = 16'd79;
	logic [1:0]  txe_s    = 2'b11;
	logic [7:0]  txe_hist = 8'h00;
	logic        wr_q     = 1'b0;
	logic        bp_on    = 1'b0;
	int          bp_wait  = 0;
	int          cycles   = 0;
	int          checks   = 0;
	int          errors   = 0;

	ft_packet_loopback #(
		.RD_CYCLE        (RD_CYCLE),
		.RD_STROBE_START (RD_STROBE_START),
		.RD_STROBE_STOP  (RD_STROBE_STOP),
		.RD_SAMPLE       (RD_SAMPLE),
		.WR_CYCLE        (WR_CYCLE),
		.WR_STROBE_START (WR_STROBE_START),
		.WR_STROBE_STOP  (WR_STROBE_STOP),
		.WR_DRIVE_START  (WR_DRIVE_START),
		.WR_DRIVE_STOP   (WR_DRIVE_STOP)
	) uut (
		.clk           (clk),
		.arst_n        (arst_n),
		.rxf_n         (rxf_n),
		.rd_n          (rd_n),
		.ft_data_in    (ft_data_in),
		.txe_n         (txe_n),
		.wr            (wr),
		.ft_data_out   (ft_data_out),
		.ft_oe         (ft_oe),
		.usb_active    (usb_active),
		.packet_active (packet_active)
	);

	always #50 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	//====================================================================
	// FIFO chip model
	//====================================================================

	// Data present while the request queue has bytes
	always @(posedge clk) begin
		rxf_n      <= req_q.size() == 0;
		ft_data_in <= (req_q.size() != 0) ? req_q[0] : 8'h00;
	end

	// End of read strobe consumes the byte
	always @(posedge rd_n) begin
		if (arst_n && req_q.size() != 0) begin
			void'(req_q.pop_front());
		end
	end

	// Chip latches on wr falling while the bus is driven
	always @(negedge wr) begin
		if (arst_n) begin
			check_bit("ft_oe", ft_oe, 1'b1);
			check_bit("usb_active", usb_active, 1'b1);
			reply_q.push_back(ft_data_out);
		end
	end

	// Chip full in LFSR stretches while back-pressure is on
	always @(posedge clk) begin
		if (!bp_on) begin
			txe_n   <= 1'b0;
			bp_wait <= 0;
		end else if (bp_wait == 0) begin
			if (bp_q.size() != 0) begin
				txe_n   <= !txe_n;
				bp_wait <= bp_q.pop_front();
			end else begin
				txe_n <= 1'b0;
			end
		end else begin
			bp_wait <= bp_wait - 1;
		end
	end

	// Own copy of the txe_n synchronizer plus history
	always @(posedge clk) begin
		if (!arst_n) begin
			txe_s <= 2'b11;
		end else begin
			txe_s <= {txe_s[0], txe_n};
		end
		txe_hist <= {txe_hist[6:0], txe_s[1]};
		wr_q     <= wr;
		// wr rises WR_STROBE_START+1 edges after the transfer
		if (wr === 1'b1 && wr_q === 1'b0) begin
			check_bit("txe_n synchronized at write start",
				txe_hist[WR_STROBE_START + 1], 1'b0);
		end
	end

	//====================================================================
	// Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	//====================================================================
	function automatic logic lfsr_step();
		logic fb;
		fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	// One step per bit taken
	function automatic int lfsr_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_step());
		end
		return v;
	endfunction

	//====================================================================
	// Compare tasks
	//====================================================================
	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err0);
		end
	endtask

	//====================================================================
	// Frame builders
	//====================================================================
	task automatic push_header(ref byte_t q[$]);
		for (int i = 0; i < HEADER_COUNT; i++) begin
			q.push_back(HEADER_SYMBOL);
		end
	endtask

	// Little endian
	task automatic push_word(ref byte_t q[$], input word_t w);
		q.push_back(w[7:0]);
		q.push_back(w[15:8]);
	endtask

	// bad_trl is the index of the zeroed trailer byte or -1
	task automatic push_frame(ref byte_t q[$], input int pay_bytes, input word_t service,
			input int bad_trl);
		word_t length;
		length = word_t'(4 + pay_bytes + TRAILER_COUNT);
		push_header(q);
		push_word(q, length);
		push_word(q, service);
		for (int i = 0; i < pay_bytes; i++) begin
			q.push_back(byte_t'(lfsr_bits(8)));
		end
		for (int i = 0; i < TRAILER_COUNT; i++) begin
			q.push_back((i == bad_trl) ? 8'h00 : TRAILER_SYMBOL);
		end
	endtask

	// Header, length 12, error service, trailer
	task automatic push_error_reply(ref byte_t q[$]);
		push_header(q);
		push_word(q, MIN_LENGTH);
		push_word(q, ERROR_SERVICE);
		for (int i = 0; i < TRAILER_COUNT; i++) begin
			q.push_back(TRAILER_SYMBOL);
		end
	endtask

	// Feed stim_q to the chip, wait for the reply and compare with exp_q
	task automatic exchange(input string name);
		int   err0;
		logic parsed;
		err0   = errors;
		parsed = 1'b0;
		@(negedge clk);
		foreach (stim_q[i]) begin
			req_q.push_back(stim_q[i]);
		end
		while (reply_q.size() < exp_q.size()) begin
			@(posedge clk);
			if (packet_active) begin
				parsed = 1'b1;
			end
		end
		while (usb_active || packet_active || req_q.size() != 0) begin
			@(posedge clk);
		end
		// Room for a surplus byte to reach the chip
		repeat (2 * WR_CYCLE) @(posedge clk);
		check_bit("packet_active", parsed, 1'b1);
		if (reply_q.size() != exp_q.size()) begin
			errors++;
			$display("Reply has %0d bytes, expected %0d", reply_q.size(), exp_q.size());
		end
		for (int i = 0; i < exp_q.size() && i < reply_q.size(); i++) begin
			check_byte($sformatf("ft_data_out[%0d]", i), reply_q[i], exp_q[i]);
		end
		stim_q.delete();
		exp_q.delete();
		reply_q.delete();
		report_test(name, err0);
	endtask

	//====================================================================
	// Directed tests
	//====================================================================
	task automatic reset_values();
		int err0;
		err0 = errors;
		@(posedge clk);
		check_bit("rd_n", rd_n, 1'b1);
		check_bit("wr", wr, 1'b0);
		check_bit("ft_oe", ft_oe, 1'b0);
		check_bit("usb_active", usb_active, 1'b0);
		check_bit("packet_active", packet_active, 1'b0);
		report_test("reset_state", err0);
	endtask

	// Junk and a short 0x55 run ahead of the frame
	task automatic echo_with_noise();
		byte_t noise [6];
		noise = '{8'h3C, 8'h55, 8'h55, 8'h55, 8'h55, 8'h07};
		foreach (noise[i]) begin
			stim_q.push_back(noise[i]);
		end
		push_frame(exp_q, 8, 16'hCCCC, -1);
		foreach (exp_q[i]) begin
			stim_q.push_back(exp_q[i]);
		end
		exchange("loopback");
	endtask

	task automatic echo_empty();
		push_frame(exp_q, 0, 16'h0001, -1);
		stim_q = exp_q;
		exchange("empty_payload");
	endtask

	// Frame ends right after the length field
	task automatic bad_length_reply();
		push_header(stim_q);
		push_word(stim_q, 16'd10);
		push_error_reply(exp_q);
		exchange("bad_length");
	endtask

	task automatic bad_trailer_reply();
		push_frame(stim_q, 4, 16'h2222, 2);
		push_error_reply(exp_q);
		exchange("bad_trailer");
	endtask

	task automatic echo_under_backpressure();
		push_frame(exp_q, 16, 16'h5A01, -1);
		stim_q = exp_q;
		for (int i = 0; i < 128; i++) begin
			bp_q.push_back(2 + lfsr_bits(4));
		end
		@(negedge clk);
		bp_on = 1'b1;
		exchange("back_pressure");
		@(negedge clk);
		bp_on = 1'b0;
		bp_q.delete();
	endtask

	initial begin
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		reset_values();
		echo_with_noise();
		echo_empty();
		bad_length_reply();
		bad_trailer_reply();
		echo_under_backpressure();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hw/ft_loop_pkg.sv
hw/ft_rx_port.sv
hw/packet_parser.sv
hw/payload_ram.sv
hw/reply_sender.sv
hw/ft_tx_port.sv
hw/ft_packet_loopback.sv
tb/ft_packet_loopback_tb.sv

//--- Makefile
# Verilator build and run of the FT245 packet loopback testbench

TOP = ft_packet_loopback_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@grep -qx "Simulation passed" sim.log || { echo "FAIL: see sim.log"; exit 1; }
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log
